/* src/syscfg_settings.svh */
`ifndef SYSCFG_SETTINGS_SVH
`define SYSCFG_SETTINGS_SVH

`default_nettype none

// Bus and register widths
`define SYSCFG_DATA_W 32
`define SYSCFG_ADDR_W 16

// Register offsets inside one controller window
`define SYSCFG_SR_OFS  8'h00
`define SYSCFG_MR_OFS  8'h04
`define SYSCFG_BAR_OFS 8'h08
`define SYSCFG_IER_OFS 8'h0C

// Address bit choosing controller 0 or 1, offsets live below it
`define SYSCFG_TGT_SEL_BIT 8
`define SYSCFG_TGT_NUM     2

// Where a core boots until software moves it
`define SYSCFG_RST_BOOT_ADDR 16'h1000

`default_nettype wire

`endif

/* src/syscfg_pkg.sv */
`include "syscfg_settings.svh"
`default_nettype none

package syscfg_pkg;

    typedef logic [`SYSCFG_DATA_W-1:0] data_t;
    typedef logic [`SYSCFG_ADDR_W-1:0] addr_t;

    // Bit 1 stopped, bit 0 paused
    typedef logic [1:0] status_t;

    // Action codes written to MR
    typedef logic [2:0] action_t;

    localparam action_t ACT_IDLE   = 3'd0;
    localparam action_t ACT_RESUME = 3'd1;
    localparam action_t ACT_PAUSE  = 3'd2;
    localparam action_t ACT_STOP   = 3'd3;
    localparam action_t ACT_RESET  = 3'd4;

    // Controller action FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESUME_WAIT,
        ST_PAUSE_WAIT,
        ST_STOP_WAIT,
        ST_RESET_STOP
    } tgt_state_e;

endpackage

`default_nettype wire

/* src/syscfg_interconnect.sv */
`include "syscfg_settings.svh"
`default_nettype none

module syscfg_interconnect (
    input  wire logic              seq,
    input  wire logic              arst_n,
    // Host master
    input  wire logic              h_psel,
    input  wire logic              h_penable,
    input  wire logic              h_pwrite,
    input  wire syscfg_pkg::addr_t h_paddr,
    input  wire syscfg_pkg::data_t h_pwdata,
    output      syscfg_pkg::data_t h_prdata,
    output      logic              h_pready,
    output      logic              h_pslverr,
    // Debug master
    input  wire logic              d_psel,
    input  wire logic              d_penable,
    input  wire logic              d_pwrite,
    input  wire syscfg_pkg::addr_t d_paddr,
    input  wire syscfg_pkg::data_t d_pwdata,
    output      syscfg_pkg::data_t d_prdata,
    output      logic              d_pready,
    output      logic              d_pslverr,
    // Shared bus towards the controllers
    output      logic              s_psel0,
    output      logic              s_psel1,
    output      logic              s_penable,
    output      logic              s_pwrite,
    output      syscfg_pkg::addr_t s_paddr,
    output      syscfg_pkg::data_t s_pwdata,
    input  wire syscfg_pkg::data_t s_prdata0,
    input  wire syscfg_pkg::data_t s_prdata1,
    input  wire logic              s_pready0,
    input  wire logic              s_pready1,
    input  wire logic              s_pslverr0,
    input  wire logic              s_pslverr1
);
    import syscfg_pkg::*;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_SETUP,
        IC_ACCESS,
        IC_RESP
    } ic_state_e;

    ic_state_e                  state_q;
    logic                       gnt_q;      // 1 while debug owns the bus
    logic                       nxt_gnt;
    addr_t                      req_addr;
    logic                       req_oor;
    logic                       sel_bit;
    logic                       s_pready;
    logic [`SYSCFG_TGT_NUM-1:0] s_psel_vec;
    data_t                      rdata_q;
    logic                       slverr_q;

    // Alternate on a tie, the last owner doubles as pointer
    assign nxt_gnt  = (h_psel && d_psel) ? !gnt_q : d_psel;
    assign req_addr = nxt_gnt ? d_paddr : h_paddr;
    // Any bit above the select bit is outside both windows
    assign req_oor  = |req_addr[`SYSCFG_ADDR_W-1:`SYSCFG_TGT_SEL_BIT+1];

    // Granted master is held stable, so it is replayed directly
    assign s_paddr   = gnt_q ? d_paddr : h_paddr;
    assign s_pwdata  = gnt_q ? d_pwdata : h_pwdata;
    assign s_pwrite  = gnt_q ? d_pwrite : h_pwrite;
    assign s_penable = (state_q == IC_ACCESS);
    assign sel_bit   = s_paddr[`SYSCFG_TGT_SEL_BIT];
    assign s_pready  = sel_bit ? s_pready1 : s_pready0;

    always_comb begin
        s_psel_vec = '0;
        if (state_q == IC_SETUP || state_q == IC_ACCESS) begin
            s_psel_vec[sel_bit] = 1'b1;
        end
    end

    assign s_psel0 = s_psel_vec[0];
    assign s_psel1 = s_psel_vec[1];

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= IC_IDLE;
            gnt_q    <= 1'b1;
            slverr_q <= 1'b0;
        end else begin
            case (state_q)
                IC_IDLE: begin
                    if (h_psel || d_psel) begin
                        gnt_q <= nxt_gnt;
                        // Decode errors never reach a controller
                        slverr_q <= req_oor;
                        state_q  <= req_oor ? IC_RESP : IC_SETUP;
                    end
                end
                IC_SETUP: state_q <= IC_ACCESS;
                IC_ACCESS: begin
                    if (s_pready) begin
                        slverr_q <= sel_bit ? s_pslverr1 : s_pslverr0;
                        state_q  <= IC_RESP;
                    end
                end
                default: state_q <= IC_IDLE;
            endcase
        end
    end

    // Response data, cleared so a decode error returns zero
    always_ff @(posedge seq) begin
        if (state_q == IC_IDLE) begin
            rdata_q <= '0;
        end else if (state_q == IC_ACCESS && s_pready) begin
            rdata_q <= sel_bit ? s_prdata1 : s_prdata0;
        end
    end

    assign h_pready  = (state_q == IC_RESP) && !gnt_q && h_penable;
    assign d_pready  = (state_q == IC_RESP) && gnt_q && d_penable;
    assign h_pslverr = h_pready && slverr_q;
    assign d_pslverr = d_pready && slverr_q;
    assign h_prdata  = gnt_q ? '0 : rdata_q;
    assign d_prdata  = gnt_q ? rdata_q : '0;

    // At most one controller selected, and only for a live in-range request
    assert property (@(posedge seq) disable iff (!arst_n)
        (|s_psel_vec) |-> ($onehot(s_psel_vec) && (gnt_q ? d_psel : h_psel)
            && (s_paddr[`SYSCFG_ADDR_W-1:`SYSCFG_TGT_SEL_BIT+1] == '0)));

endmodule

`default_nettype wire

/* src/syscfg_tgt.sv */
`include "syscfg_settings.svh"
`default_nettype none

module syscfg_tgt (
    input  wire logic              seq,
    input  wire logic              arst_n,
    // APB slave
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire syscfg_pkg::addr_t paddr,
    input  wire syscfg_pkg::data_t pwdata,
    output      syscfg_pkg::data_t prdata,
    output      logic              pready,
    output      logic              pslverr,
    input  wire syscfg_pkg::data_t irq_vec,
    // Core side
    output      logic              tgt_rst,
    output      logic              tgt_pause_req,
    input  wire logic              tgt_pause_ack,
    output      syscfg_pkg::addr_t tgt_boot_addr,
    output      logic              tgt_irq
);
    import syscfg_pkg::*;

    localparam int OFS_W = `SYSCFG_TGT_SEL_BIT;

    tgt_state_e       state_q;
    logic             boot_q;
    logic             rst_q;
    logic             req_q;
    status_t          status_q;
    action_t          mr_q;
    addr_t            bar_q;
    data_t            ier_q;
    logic [OFS_W-1:0] ofs;
    logic             access;
    logic             busy;
    logic             err;
    logic             wr_ok;
    logic             start;
    action_t          start_act;
    logic             done;

    assign ofs    = paddr[OFS_W-1:0];
    assign access = psel && penable;
    // Bootstrap counts as pending until its resume is launched
    assign busy   = (state_q != ST_IDLE) || boot_q;
    // Core has caught up with the request level
    assign done   = (tgt_pause_ack == req_q);

    always_comb begin
        case (ofs)
            `SYSCFG_SR_OFS:  err = pwrite;
            `SYSCFG_MR_OFS:  err = pwrite && busy;
            `SYSCFG_BAR_OFS: err = pwrite && busy;
            `SYSCFG_IER_OFS: err = 1'b0;
            default:         err = 1'b1;
        endcase
    end

    always_comb begin
        case (ofs)
            `SYSCFG_SR_OFS:  prdata = data_t'(status_q);
            `SYSCFG_MR_OFS:  prdata = data_t'(mr_q);
            `SYSCFG_BAR_OFS: prdata = data_t'(bar_q);
            `SYSCFG_IER_OFS: prdata = ier_q;
            default:         prdata = '0;
        endcase
    end

    // Zero wait states
    assign pready  = access;
    assign pslverr = access && err;
    assign wr_ok   = access && pwrite && !err;

    assign start     = boot_q || (wr_ok && ofs == `SYSCFG_MR_OFS);
    assign start_act = boot_q ? ACT_RESUME : action_t'(pwdata[2:0]);

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            mr_q  <= ACT_IDLE;
            bar_q <= `SYSCFG_RST_BOOT_ADDR;
            ier_q <= '0;
        end else if (wr_ok) begin
            case (ofs)
                `SYSCFG_MR_OFS:  mr_q <= action_t'(pwdata[2:0]);
                `SYSCFG_BAR_OFS: bar_q <= pwdata[`SYSCFG_ADDR_W-1:0];
                `SYSCFG_IER_OFS: ier_q <= pwdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            boot_q   <= 1'b1;
            rst_q    <= 1'b1;
            req_q    <= 1'b1;
            status_q <= 2'b11;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    boot_q <= 1'b0;
                    if (start) begin
                        case (start_act)
                            ACT_RESUME: begin
                                rst_q   <= 1'b0;
                                req_q   <= 1'b0;
                                state_q <= ST_RESUME_WAIT;
                            end
                            ACT_PAUSE: begin
                                req_q   <= 1'b1;
                                state_q <= ST_PAUSE_WAIT;
                            end
                            ACT_STOP: begin
                                req_q   <= 1'b1;
                                state_q <= ST_STOP_WAIT;
                            end
                            ACT_RESET: begin
                                req_q   <= 1'b1;
                                state_q <= ST_RESET_STOP;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_RESUME_WAIT: begin
                    // After a RESET stop, reset drops here one cycle late
                    rst_q <= 1'b0;
                    req_q <= 1'b0;
                    if (!req_q && done) begin
                        status_q <= 2'b00;
                        state_q  <= ST_IDLE;
                    end
                end
                ST_PAUSE_WAIT: begin
                    if (done) begin
                        status_q <= {rst_q, 1'b1};
                        state_q  <= ST_IDLE;
                    end
                end
                ST_STOP_WAIT: begin
                    if (done) begin
                        rst_q    <= 1'b1;
                        status_q <= 2'b11;
                        state_q  <= ST_IDLE;
                    end
                end
                ST_RESET_STOP: begin
                    // Stop first, then fall into the resume step
                    if (done) begin
                        rst_q    <= 1'b1;
                        status_q <= 2'b11;
                        state_q  <= ST_RESUME_WAIT;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign tgt_rst       = rst_q;
    assign tgt_pause_req = req_q;
    assign tgt_boot_addr = bar_q;
    assign tgt_irq       = |(irq_vec & ier_q);

    // Core must be parked before its reset goes up
    assert property (@(posedge seq) disable iff (!arst_n)
        $rose(tgt_rst) |-> (tgt_pause_ack == tgt_pause_req));

    // Answer only in an access cycle that follows a setup cycle
    assert property (@(posedge seq) disable iff (!arst_n)
        pready |-> (psel && penable && $past(psel && !penable)));

endmodule

`default_nettype wire

/* src/syscfg_top.sv */
`default_nettype none

module syscfg_top (
    input  wire logic              seq,
    input  wire logic              arst_n,
    // Host master port
    input  wire logic              h_psel,
    input  wire logic              h_penable,
    input  wire logic              h_pwrite,
    input  wire syscfg_pkg::addr_t h_paddr,
    input  wire syscfg_pkg::data_t h_pwdata,
    output      syscfg_pkg::data_t h_prdata,
    output      logic              h_pready,
    output      logic              h_pslverr,
    // Debug master port
    input  wire logic              d_psel,
    input  wire logic              d_penable,
    input  wire logic              d_pwrite,
    input  wire syscfg_pkg::addr_t d_paddr,
    input  wire syscfg_pkg::data_t d_pwdata,
    output      syscfg_pkg::data_t d_prdata,
    output      logic              d_pready,
    output      logic              d_pslverr,
    // Shared interrupt sources and the two cores
    input  wire syscfg_pkg::data_t irq_vec,
    input  wire logic              tgt_pause_ack0,
    input  wire logic              tgt_pause_ack1,
    output      logic              tgt_rst0,
    output      logic              tgt_pause_req0,
    output      syscfg_pkg::addr_t tgt_boot_addr0,
    output      logic              tgt_irq0,
    output      logic              tgt_rst1,
    output      logic              tgt_pause_req1,
    output      syscfg_pkg::addr_t tgt_boot_addr1,
    output      logic              tgt_irq1
);
    import syscfg_pkg::*;

    // Shared bus between interconnect and controllers
    logic  s_psel0;
    logic  s_psel1;
    logic  s_penable;
    logic  s_pwrite;
    addr_t s_paddr;
    data_t s_pwdata;
    data_t s_prdata0;
    data_t s_prdata1;
    logic  s_pready0;
    logic  s_pready1;
    logic  s_pslverr0;
    logic  s_pslverr1;

    syscfg_interconnect u_ic (.*);

    syscfg_tgt u_tgt0 (
        .*,
        .psel          (s_psel0),
        .penable       (s_penable),
        .pwrite        (s_pwrite),
        .paddr         (s_paddr),
        .pwdata        (s_pwdata),
        .prdata        (s_prdata0),
        .pready        (s_pready0),
        .pslverr       (s_pslverr0),
        .tgt_rst       (tgt_rst0),
        .tgt_pause_req (tgt_pause_req0),
        .tgt_pause_ack (tgt_pause_ack0),
        .tgt_boot_addr (tgt_boot_addr0),
        .tgt_irq       (tgt_irq0)
    );

    syscfg_tgt u_tgt1 (
        .*,
        .psel          (s_psel1),
        .penable       (s_penable),
        .pwrite        (s_pwrite),
        .paddr         (s_paddr),
        .pwdata        (s_pwdata),
        .prdata        (s_prdata1),
        .pready        (s_pready1),
        .pslverr       (s_pslverr1),
        .tgt_rst       (tgt_rst1),
        .tgt_pause_req (tgt_pause_req1),
        .tgt_pause_ack (tgt_pause_ack1),
        .tgt_boot_addr (tgt_boot_addr1),
        .tgt_irq       (tgt_irq1)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic seq,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        seq = 1'b0;
        forever #50 seq = ~seq;
    end

    // Reset held for 8 cycles, released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge seq);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/syscfg_checker.sv */
`default_nettype none

module syscfg_checker (
    input  wire syscfg_pkg::addr_t tgt_boot_addr0,
    input  wire syscfg_pkg::addr_t tgt_boot_addr1,
    input  wire logic              tgt_irq0,
    input  wire logic              tgt_irq1,
    input  wire logic              tgt_rst0,
    input  wire logic              tgt_rst1,
    input  wire logic              tgt_pause_req0,
    input  wire logic              tgt_pause_req1,
    output int                     tests,
    output int                     errors
);
    timeunit 1ns;
    timeprecision 1ps;

    import syscfg_pkg::*;

    initial begin
        tests  = 0;
        errors = 0;
    end

    // Value compare, bit 32 carries slverr where it matters
    task automatic check(input string name, input logic [32:0] exp, input logic [32:0] act);
        tests = tests + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    // Boot address taken straight from the core-side port
    task automatic check_boot(input string name, input logic core, input addr_t exp);
        addr_t act;
        act = core ? tgt_boot_addr1 : tgt_boot_addr0;
        tests = tests + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    // Interrupt lines as {irq1, irq0}
    task automatic check_irq(input string name, input logic [1:0] exp);
        logic [1:0] act;
        act = {tgt_irq1, tgt_irq0};
        tests = tests + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    // Core reset and pause request as {rst, req}
    task automatic check_core(input string name, input logic core, input logic [1:0] exp);
        logic [1:0] act;
        act = core ? {tgt_rst1, tgt_pause_req1} : {tgt_rst0, tgt_pause_req0};
        tests = tests + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end else begin
            $display("ok  %s", name);
        end
    endtask

    task automatic fail(input string name, input string what);
        tests  = tests + 1;
        errors = errors + 1;
        $display("%s failed: %s", name, what);
    endtask

    task automatic report_counts();
        $display("Tests run %0d, errors %0d", tests, errors);
    endtask

endmodule

`default_nettype wire

/* testbench/syscfg_tb.sv */
`default_nettype none

module syscfg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import syscfg_pkg::*;

    localparam int POLL_MAX = 40;

    logic  seq;
    logic  arst_n;
    logic  h_psel, h_penable, h_pwrite;
    addr_t h_paddr;
    data_t h_pwdata, h_prdata;
    logic  h_pready, h_pslverr;
    logic  d_psel, d_penable, d_pwrite;
    addr_t d_paddr;
    data_t d_pwdata, d_prdata;
    logic  d_pready, d_pslverr;
    data_t irq_vec;
    logic  tgt_pause_ack0, tgt_pause_ack1;
    logic  tgt_rst0, tgt_pause_req0, tgt_irq0;
    logic  tgt_rst1, tgt_pause_req1, tgt_irq1;
    addr_t tgt_boot_addr0, tgt_boot_addr1;
    int    n_tests, n_errors;

    // Golden operations
    string n_q[$];
    string op_q[$];
    string port_q[$];
    logic [31:0] addr_q[$], wdata_q[$], exp_q[$], err_q[$];

    int   seed = 567;
    int   cycles = 0;
    int   limit = 0;
    logic hold [2];

    tb_clock u_clk (.seq(seq), .arst_n(arst_n));

    syscfg_top dut (.*);

    syscfg_checker u_chk (
        .tgt_boot_addr0 (tgt_boot_addr0),
        .tgt_boot_addr1 (tgt_boot_addr1),
        .tgt_irq0       (tgt_irq0),
        .tgt_irq1       (tgt_irq1),
        .tgt_rst0       (tgt_rst0),
        .tgt_rst1       (tgt_rst1),
        .tgt_pause_req0 (tgt_pause_req0),
        .tgt_pause_req1 (tgt_pause_req1),
        .tests          (n_tests),
        .errors         (n_errors)
    );

    initial begin
        h_psel = 1'b0;
        h_penable = 1'b0;
        h_pwrite = 1'b0;
        h_paddr = '0;
        h_pwdata = '0;
        d_psel = 1'b0;
        d_penable = 1'b0;
        d_pwrite = 1'b0;
        d_paddr = '0;
        d_pwdata = '0;
        irq_vec = '0;
        tgt_pause_ack0 = 1'b1;
        tgt_pause_ack1 = 1'b1;
        hold[0] = 1'b0;
        hold[1] = 1'b0;
    end

    // Core model, ack follows req after 2 to 9 cycles unless held
    task automatic core_model(input logic core);
        int dly;
        forever begin
            @(posedge seq);
            if ((core ? (tgt_pause_req1 != tgt_pause_ack1)
                      : (tgt_pause_req0 != tgt_pause_ack0)) && !hold[core]) begin
                dly = 2 + ($unsigned($random(seed)) % 8);
                repeat (dly) @(posedge seq);
                if (core) tgt_pause_ack1 <= tgt_pause_req1;
                else tgt_pause_ack0 <= tgt_pause_req0;
            end
        end
    endtask

    initial core_model(1'b0);
    initial core_model(1'b1);

    // One APB transfer on the host or debug port
    task automatic apb_xfer(input logic dbg, input logic wr, input addr_t a, input data_t wd,
                            output data_t rd, output logic err);
        @(posedge seq);
        if (dbg) begin
            d_psel    <= 1'b1;
            d_penable <= 1'b0;
            d_pwrite  <= wr;
            d_paddr   <= a;
            d_pwdata  <= wd;
        end else begin
            h_psel    <= 1'b1;
            h_penable <= 1'b0;
            h_pwrite  <= wr;
            h_paddr   <= a;
            h_pwdata  <= wd;
        end
        @(posedge seq);
        if (dbg) d_penable <= 1'b1;
        else h_penable <= 1'b1;
        // Sample on the falling edge, away from the registers
        @(negedge seq);
        while (!(dbg ? d_pready : h_pready)) @(negedge seq);
        rd  = dbg ? d_prdata : h_prdata;
        err = dbg ? d_pslverr : h_pslverr;
        @(posedge seq);
        if (dbg) begin
            d_psel    <= 1'b0;
            d_penable <= 1'b0;
        end else begin
            h_psel    <= 1'b0;
            h_penable <= 1'b0;
        end
    endtask

    task automatic run_op(input int i);
        data_t rd, rd_d;
        logic  err, err_d;
        logic  dbg, wr;
        logic  seen;
        int    k;
        dbg = (port_q[i] == "d");
        case (op_q[i])
            "W", "R": begin
                wr = (op_q[i] == "W");
                apb_xfer(dbg, wr, addr_t'(addr_q[i]), wdata_q[i], rd, err);
                if (wr) u_chk.check(n_q[i], {err_q[i][0], 32'h0}, {err, 32'h0});
                else u_chk.check(n_q[i], {err_q[i][0], exp_q[i]}, {err, rd});
            end
            "P": begin
                k = 0;
                seen = 1'b0;
                while (k < POLL_MAX && !seen) begin
                    apb_xfer(dbg, 1'b0, addr_t'(addr_q[i]), '0, rd, err);
                    seen = !err && (rd[1:0] == exp_q[i][1:0]);
                    k++;
                end
                if (seen) begin
                    // Stopped means reset high, paused or stopped means req high
                    @(negedge seq);
                    u_chk.check_core(n_q[i], addr_q[i][8],
                                     {exp_q[i][1], |exp_q[i][1:0]});
                end else begin
                    u_chk.fail(n_q[i], "status poll never reached the expected value");
                end
            end
            "C": begin
                // Debug takes the other controller and the next data word
                wr = (port_q[i] == "w");
                fork
                    apb_xfer(1'b0, wr, addr_t'(addr_q[i]), wdata_q[i], rd, err);
                    apb_xfer(1'b1, wr, addr_t'(addr_q[i] ^ 32'h100), wdata_q[i] + 1, rd_d, err_d);
                join
                if (wr) begin
                    rd = '0;
                    rd_d = '0;
                end
                u_chk.check({n_q[i], "_h"}, {err_q[i][0], wr ? 32'h0 : exp_q[i]}, {err, rd});
                u_chk.check({n_q[i], "_d"}, {err_q[i][0], wr ? 32'h0 : exp_q[i] + 1},
                            {err_d, rd_d});
            end
            "B": begin
                @(negedge seq);
                u_chk.check_boot(n_q[i], port_q[i] == "1", addr_t'(exp_q[i]));
            end
            "I": begin
                @(posedge seq);
                irq_vec <= wdata_q[i];
                @(negedge seq);
                u_chk.check_irq(n_q[i], exp_q[i][1:0]);
            end
            "H": begin
                hold[port_q[i] == "1"] = wdata_q[i][0];
            end
            default: u_chk.fail(n_q[i], "unknown operation in the golden file");
        endcase
    endtask

    // Cycle budget scales with the operation count
    always @(posedge seq) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Run stopped after %0d cycles, the DUT did not answer in time", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int    fd;
        int    cnt;
        string line, nm, op, pt;
        logic [31:0] a, w, e, r;
        fd = $fopen("testbench/syscfg_golden.txt", "r");
        if (fd == 0) begin
            $display("Golden file could not be opened");
            $display("Finished with errors");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %s %s %h %h %h %h", nm, op, pt, a, w, e, r);
                    if (cnt == 7) begin
                        n_q.push_back(nm);
                        op_q.push_back(op);
                        port_q.push_back(pt);
                        addr_q.push_back(a);
                        wdata_q.push_back(w);
                        exp_q.push_back(e);
                        err_q.push_back(r);
                    end
                end
            end
            $fclose(fd);
            limit = 40 * n_q.size();
            wait (arst_n === 1'b1);
            for (int i = 0; i < n_q.size(); i++) begin
                run_op(i);
            end
            repeat (2) @(posedge seq);
            u_chk.report_counts();
            if (n_errors == 0 && n_tests > 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/syscfg_golden.txt */
# name op port addr wdata exp_rdata exp_err, numbers in hex
# ops W write, R read, P poll SR, C both masters, B boot address, I irq_vec, H hold ack
rst_boot0 B 0 0000 00000000 00001000 0
rst_boot1 B 1 0000 00000000 00001000 0
rst_irq I 0 0000 00000000 00000000 0
boot_poll0 P h 0000 00000000 00000000 0
boot_poll1 P d 0100 00000000 00000000 0
act_pause W h 0004 00000002 00000000 0
act_pause_sr P h 0000 00000000 00000001 0
act_stop W h 0004 00000003 00000000 0
act_stop_sr P h 0000 00000000 00000003 0
act_reset W h 0004 00000004 00000000 0
act_reset_sr P h 0000 00000000 00000000 0
act_pause2 W h 0004 00000002 00000000 0
act_pause2_sr P h 0000 00000000 00000001 0
act_resume W h 0004 00000001 00000000 0
act_resume_sr P h 0000 00000000 00000000 0
mr_read R h 0004 00000000 00000001 0
busy_hold H 1 0000 00000001 00000000 0
busy_stop W d 0104 00000003 00000000 0
busy_mr W d 0104 00000001 00000000 1
busy_bar W d 0108 00002000 00000000 1
busy_bar_rd R d 0108 00000000 00001000 0
busy_release H 1 0000 00000000 00000000 0
busy_sr P d 0100 00000000 00000003 0
busy_resume W d 0104 00000001 00000000 0
busy_resume_sr P d 0100 00000000 00000000 0
bar_wr W h 0008 0000abcd 00000000 0
bar_rd R h 0008 00000000 0000abcd 0
bar_out B 0 0000 00000000 0000abcd 0
sr_wr W h 0000 00000001 00000000 1
oor_rd R d 0200 00000000 00000000 1
irq_set I 0 0000 fffffff0 00000000 0
ier_wr W h 000c ffffffff 00000000 0
irq_on I 0 0000 fffffff0 00000001 0
ier_rd R h 000c 00000000 ffffffff 0
ier_clr W h 000c 00000000 00000000 0
irq_off I 0 0000 fffffff0 00000000 0
cc_wr C w 0008 00001234 00000000 0
cc_rd C r 0008 00000000 00001234 0
cc_boot0 B 0 0000 00000000 00001234 0
cc_boot1 B 1 0000 00000000 00001235 0

/* list.f */
+incdir+src
src/syscfg_pkg.sv
src/syscfg_interconnect.sv
src/syscfg_tgt.sv
src/syscfg_top.sv
testbench/tb_clock.sv
testbench/syscfg_checker.sv
testbench/syscfg_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module syscfg_tb -f list.f -o syscfg_sim

out=$(./obj_dir/syscfg_sim)
echo "$out"

if grep -q "Finished with no errors" <<< "$out"; then
    exit 0
else
    exit 1
fi
